// File: Bender.yml
package:
  name: dnc_read_vectors

sources:
  # RTL, package first
  - files:
      - hdl/dnc_read_pkg.sv
      - hdl/dnc_matrix_loader.sv
      - hdl/dnc_operand_buffer.sv
      - hdl/dnc_read_engine.sv
      - hdl/dnc_read_vectors.sv

  # Testbench, includes the scenario tasks from verification
  - target: test
    include_dirs:
      - verification
    files:
      - verification/dnc_read_vectors_tb.sv

// File: filelist.f
+incdir+verification
hdl/dnc_read_pkg.sv
hdl/dnc_matrix_loader.sv
hdl/dnc_operand_buffer.sv
hdl/dnc_read_engine.sv
hdl/dnc_read_vectors.sv
verification/dnc_read_vectors_tb.sv

// File: hdl/dnc_matrix_loader.sv
// Loader that turns the M and w element strobes into operand buffer write ports
`timescale 1ns/1ps

module dnc_matrix_loader
  import dnc_read_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    START,
  input  data_t   m_in,
  input  logic    m_in_j_enable,
  input  logic    m_in_k_enable,
  input  data_t   w_in,
  input  logic    w_in_i_enable,
  input  logic    w_in_j_enable,
  output logic    m_wr_en,
  output m_addr_t m_wr_addr,
  output data_t   m_wr_data,
  output logic    w_wr_en,
  output w_addr_t w_wr_addr,
  output data_t   w_wr_data
);

  // Stored stream positions, row starts at all ones
  index_t m_row;
  index_t m_col;
  index_t w_row;
  index_t w_col;

  // Position of the element in the current cycle
  index_t m_row_cur;
  index_t m_col_cur;
  index_t w_row_cur;
  index_t w_col_cur;

  // Row strobe steps the row and restarts the column
  always_comb begin
    m_row_cur = m_in_j_enable ? index_t'(m_row + 1'b1) : m_row;
    m_col_cur = m_in_j_enable ? '0 : m_col;
    w_row_cur = w_in_i_enable ? index_t'(w_row + 1'b1) : w_row;
    w_col_cur = w_in_i_enable ? '0 : w_col;
  end

  //////////////////////////////
  // Position counters
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m_row <= '1;
      m_col <= '0;
      w_row <= '1;
      w_col <= '0;
    end else if (START) begin
      // Rearm both streams for the next load
      m_row <= '1;
      m_col <= '0;
      w_row <= '1;
      w_col <= '0;
    end else begin
      if (m_in_j_enable || m_in_k_enable) begin
        m_row <= m_row_cur;
        m_col <= m_in_k_enable ? index_t'(m_col_cur + 1'b1) : m_col_cur;
      end
      if (w_in_i_enable || w_in_j_enable) begin
        w_row <= w_row_cur;
        w_col <= w_in_j_enable ? index_t'(w_col_cur + 1'b1) : w_col_cur;
      end
    end
  end

  //////////////////////////////
  // Write ports
  //////////////////////////////

  // Write pulse one cycle after the element strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m_wr_en <= 1'b0;
      w_wr_en <= 1'b0;
    end else begin
      m_wr_en <= m_in_k_enable;
      w_wr_en <= w_in_j_enable;
    end
  end

  // Address and data travel with the pulse
  always_ff @(posedge CLK) begin
    m_wr_addr <= m_addr_t'(m_row_cur * MAX_W + m_col_cur);
    m_wr_data <= m_in;
    w_wr_addr <= w_addr_t'(w_row_cur * MAX_N + w_col_cur);
    w_wr_data <= w_in;
  end

endmodule

// File: hdl/dnc_operand_buffer.sv
// Operand store for M and w, one write port and one registered read port each
`timescale 1ns/1ps

module dnc_operand_buffer
  import dnc_read_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    m_wr_en,
  input  m_addr_t m_wr_addr,
  input  data_t   m_wr_data,
  input  logic    w_wr_en,
  input  w_addr_t w_wr_addr,
  input  data_t   w_wr_data,
  input  m_addr_t m_rd_addr,
  output data_t   m_rd_data,
  input  w_addr_t w_rd_addr,
  output data_t   w_rd_data
);

  // Memory matrix, row j holds word k
  data_t m_mem [MAX_N*MAX_W];

  // Read weighting, row i holds location j
  data_t w_mem [MAX_R*MAX_N];

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (m_wr_en) begin
      m_mem[m_wr_addr] <= m_wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (w_wr_en) begin
      w_mem[w_wr_addr] <= w_wr_data;
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  // One cycle from address to data
  // A write from the previous cycle is already in the array
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m_rd_data <= '0;
    end else begin
      m_rd_data <= m_mem[m_rd_addr];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_rd_data <= '0;
    end else begin
      w_rd_data <= w_mem[w_rd_addr];
    end
  end

endmodule

// File: hdl/dnc_read_engine.sv
// Read engine FSM, walks heads and words, accumulates w(i,j)*M(j,k) and streams r(i,k)
`timescale 1ns/1ps

module dnc_read_engine
  import dnc_read_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    START,
  input  size_t   size_r,
  input  size_t   size_n,
  input  size_t   size_w,
  output m_addr_t m_rd_addr,
  output w_addr_t w_rd_addr,
  input  data_t   m_rd_data,
  input  data_t   w_rd_data,
  output logic    ready,
  output data_t   r_out,
  output logic    r_out_i_enable,
  output logic    r_out_k_enable
);

  engine_state_t state;

  // Head, word and row indices
  index_t i_idx;
  index_t k_idx;
  index_t j_idx;

  // Read data valid, one cycle behind the fetch
  logic rd_valid;

  // MAC datapath
  data_t product;
  data_t acc;
  data_t acc_next;

  // Loop end flags
  logic last_j;
  logic last_k;
  logic last_i;

  //////////////////////////////
  // Buffer addresses
  //////////////////////////////

  // M read by column k, w by head i
  assign m_rd_addr = m_addr_t'(j_idx * MAX_W + k_idx);
  assign w_rd_addr = w_addr_t'(i_idx * MAX_N + j_idx);

  //////////////////////////////
  // MAC
  //////////////////////////////

  assign product = m_rd_data * w_rd_data;

  // Kept modulo 2^16
  assign acc_next = rd_valid ? data_t'(acc + product) : acc;

  assign last_j = (size_t'(j_idx) == size_n - 1'b1);
  assign last_k = (size_t'(k_idx) == size_w - 1'b1);
  assign last_i = (size_t'(i_idx) == size_r - 1'b1);

  // Completion pulse, the cycle after the last strobe
  assign ready = (state == DONE_STATE);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= IDLE_STATE;
      i_idx          <= '0;
      k_idx          <= '0;
      j_idx          <= '0;
      rd_valid       <= 1'b0;
      acc            <= '0;
      r_out          <= '0;
      r_out_i_enable <= 1'b0;
      r_out_k_enable <= 1'b0;
    end else begin
      // Defaults, strobes last one cycle
      rd_valid       <= (state == FETCH_STATE);
      acc            <= acc_next;
      r_out_i_enable <= 1'b0;
      r_out_k_enable <= 1'b0;

      case (state)
        IDLE_STATE: begin
          if (START) begin
            i_idx <= '0;
            k_idx <= '0;
            j_idx <= '0;
            acc   <= '0;
            state <= FETCH_STATE;
          end
        end

        // One read per row j
        FETCH_STATE: begin
          if (last_j) begin
            state <= ACCUMULATE_STATE;
          end else begin
            j_idx <= index_t'(j_idx + 1'b1);
          end
        end

        // Last product lands here, result goes straight out
        ACCUMULATE_STATE: begin
          r_out          <= acc_next;
          r_out_k_enable <= 1'b1;
          r_out_i_enable <= (k_idx == '0);
          state          <= EMIT_STATE;
        end

        // Step k, then i
        EMIT_STATE: begin
          j_idx <= '0;
          acc   <= '0;
          if (!last_k) begin
            k_idx <= index_t'(k_idx + 1'b1);
            state <= FETCH_STATE;
          end else if (!last_i) begin
            k_idx <= '0;
            i_idx <= index_t'(i_idx + 1'b1);
            state <= FETCH_STATE;
          end else begin
            state <= DONE_STATE;
          end
        end

        DONE_STATE: begin
          state <= IDLE_STATE;
        end

        default: begin
          state <= IDLE_STATE;
        end
      endcase
    end
  end

endmodule

// File: hdl/dnc_read_pkg.sv
// Size limits, vector types and engine states shared by the DNC read vector RTL; import with ::*
package dnc_read_pkg;

  //////////////////////////////
  // Size limits
  //////////////////////////////

  // Element and accumulator width
  localparam int unsigned DATA_SIZE = 16;

  // Read heads, memory rows, word length
  localparam int unsigned MAX_R = 4;
  localparam int unsigned MAX_N = 8;
  localparam int unsigned MAX_W = 8;

  // Derived field widths
  localparam int unsigned SIZE_WIDTH   = $clog2(MAX_N) + 1;
  localparam int unsigned INDEX_WIDTH  = $clog2(MAX_N);
  localparam int unsigned M_ADDR_WIDTH = $clog2(MAX_N * MAX_W);
  localparam int unsigned W_ADDR_WIDTH = $clog2(MAX_R * MAX_N);

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // One element of M, w or r
  typedef logic [DATA_SIZE-1:0] data_t;

  // Run-time dimension, 1 to 8
  typedef logic [SIZE_WIDTH-1:0] size_t;

  // Loop index i, j or k
  typedef logic [INDEX_WIDTH-1:0] index_t;

  // M store address, j*MAX_W + k
  typedef logic [M_ADDR_WIDTH-1:0] m_addr_t;

  // w store address, i*MAX_N + j
  typedef logic [W_ADDR_WIDTH-1:0] w_addr_t;

  //////////////////////////////
  // Engine FSM
  //////////////////////////////

  typedef enum logic [2:0] {
    IDLE_STATE,
    FETCH_STATE,
    ACCUMULATE_STATE,
    EMIT_STATE,
    DONE_STATE
  } engine_state_t;

endpackage

// File: hdl/dnc_read_vectors.sv
// Top of the DNC read vector unit, loader into operand buffer into read engine
`timescale 1ns/1ps

module dnc_read_vectors
  import dnc_read_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  START,
  output logic  READY,
  input  size_t SIZE_R_IN,
  input  size_t SIZE_N_IN,
  input  size_t SIZE_W_IN,
  input  data_t M_IN,
  input  logic  M_IN_J_ENABLE,
  input  logic  M_IN_K_ENABLE,
  input  data_t W_IN,
  input  logic  W_IN_I_ENABLE,
  input  logic  W_IN_J_ENABLE,
  output data_t R_OUT,
  output logic  R_OUT_I_ENABLE,
  output logic  R_OUT_K_ENABLE
);

  // Loader to buffer
  logic    m_wr_en;
  m_addr_t m_wr_addr;
  data_t   m_wr_data;
  logic    w_wr_en;
  w_addr_t w_wr_addr;
  data_t   w_wr_data;

  // Engine to buffer
  m_addr_t m_rd_addr;
  w_addr_t w_rd_addr;
  data_t   m_rd_data;
  data_t   w_rd_data;

  //////////////////////////////
  // Producer
  //////////////////////////////

  dnc_matrix_loader i_dnc_matrix_loader (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .m_in          (M_IN),
    .m_in_j_enable (M_IN_J_ENABLE),
    .m_in_k_enable (M_IN_K_ENABLE),
    .w_in          (W_IN),
    .w_in_i_enable (W_IN_I_ENABLE),
    .w_in_j_enable (W_IN_J_ENABLE),
    .m_wr_en       (m_wr_en),
    .m_wr_addr     (m_wr_addr),
    .m_wr_data     (m_wr_data),
    .w_wr_en       (w_wr_en),
    .w_wr_addr     (w_wr_addr),
    .w_wr_data     (w_wr_data)
  );

  //////////////////////////////
  // Operand store
  //////////////////////////////

  dnc_operand_buffer i_dnc_operand_buffer (
    .CLK       (CLK),
    .RST       (RST),
    .m_wr_en   (m_wr_en),
    .m_wr_addr (m_wr_addr),
    .m_wr_data (m_wr_data),
    .w_wr_en   (w_wr_en),
    .w_wr_addr (w_wr_addr),
    .w_wr_data (w_wr_data),
    .m_rd_addr (m_rd_addr),
    .m_rd_data (m_rd_data),
    .w_rd_addr (w_rd_addr),
    .w_rd_data (w_rd_data)
  );

  //////////////////////////////
  // Consumer
  //////////////////////////////

  dnc_read_engine i_dnc_read_engine (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .size_r         (SIZE_R_IN),
    .size_n         (SIZE_N_IN),
    .size_w         (SIZE_W_IN),
    .m_rd_addr      (m_rd_addr),
    .w_rd_addr      (w_rd_addr),
    .m_rd_data      (m_rd_data),
    .w_rd_data      (w_rd_data),
    .ready          (READY),
    .r_out          (R_OUT),
    .r_out_i_enable (R_OUT_I_ENABLE),
    .r_out_k_enable (R_OUT_K_ENABLE)
  );

endmodule

// File: verification/dnc_read_vectors_tests.svh
// Load, run and scenario tasks for the DNC read vector testbench, included in its top module

//////////////////////////////
// Operand fill
//////////////////////////////

task automatic fill_random(int r, int n, int w);
  for (int j = 0; j < n; j++) begin
    for (int k = 0; k < w; k++) begin
      m_mat[j][k] = data_t'($urandom);
    end
  end
  for (int i = 0; i < r; i++) begin
    for (int j = 0; j < n; j++) begin
      w_mat[i][j] = data_t'($urandom);
    end
  end
endtask

// Operands just under 0xFFFF, every product and sum overflows
task automatic fill_near_max(int r, int n, int w);
  for (int j = 0; j < n; j++) begin
    for (int k = 0; k < w; k++) begin
      m_mat[j][k] = data_t'(16'hFFFF - ($urandom % 16));
    end
  end
  for (int i = 0; i < r; i++) begin
    for (int j = 0; j < n; j++) begin
      w_mat[i][j] = data_t'(16'hFFFF - ($urandom % 16));
    end
  end
endtask

//////////////////////////////
// Load and run
//////////////////////////////

// M row by row, then w head by head, then one START pulse
task automatic load_and_start(int r, int n, int w);
  @(negedge CLK);
  SIZE_R_IN = size_t'(r);
  SIZE_N_IN = size_t'(n);
  SIZE_W_IN = size_t'(w);
  for (int j = 0; j < n; j++) begin
    for (int k = 0; k < w; k++) begin
      M_IN = m_mat[j][k];
      M_IN_J_ENABLE = (k == 0);
      M_IN_K_ENABLE = 1'b1;
      @(negedge CLK);
    end
  end
  M_IN_J_ENABLE = 1'b0;
  M_IN_K_ENABLE = 1'b0;
  for (int i = 0; i < r; i++) begin
    for (int j = 0; j < n; j++) begin
      W_IN = w_mat[i][j];
      W_IN_I_ENABLE = (j == 0);
      W_IN_J_ENABLE = 1'b1;
      @(negedge CLK);
    end
  end
  W_IN_I_ENABLE = 1'b0;
  W_IN_J_ENABLE = 1'b0;
  // Last write lands two edges after its strobe
  repeat (2) @(negedge CLK);
  START = 1'b1;
  @(negedge CLK);
  START = 1'b0;
endtask

task automatic run_case(int r, int n, int w);
  build_expected(r, n, w);
  load_and_start(r, n, w);
  // READY closes the run, hangs go to the watchdog
  do begin
    @(negedge CLK);
  end while (READY !== 1'b1);
  // Compare has finished its READY checks by the next edge
  @(negedge CLK);
endtask

task automatic finish_test(string name, int unsigned errors_before);
  tests_run++;
  if (error_count == errors_before) begin
    $display("Test %s finished, no errors", name);
  end else begin
    tests_failed++;
    $display("Test %s finished, %0d errors", name, error_count - errors_before);
  end
endtask

//////////////////////////////
// Scenarios
//////////////////////////////

// Quiet outputs before the first START
task automatic idle_after_reset();
  int unsigned errors_before;
  errors_before = error_count;
  repeat (10) begin
    @(negedge CLK);
    check_count += 4;
    if (READY !== 1'b0) begin
      report_mismatch("READY", 0, READY);
    end
    if (R_OUT_I_ENABLE !== 1'b0) begin
      report_mismatch("R_OUT_I_ENABLE", 0, R_OUT_I_ENABLE);
    end
    if (R_OUT_K_ENABLE !== 1'b0) begin
      report_mismatch("R_OUT_K_ENABLE", 0, R_OUT_K_ENABLE);
    end
    if (R_OUT !== '0) begin
      report_mismatch("R_OUT", 0, R_OUT);
    end
  end
  finish_test("idle after reset", errors_before);
endtask

task automatic full_size_random();
  int unsigned errors_before;
  errors_before = error_count;
  fill_random(MAX_R, MAX_N, MAX_W);
  run_case(MAX_R, MAX_N, MAX_W);
  finish_test("full size 4x8x8", errors_before);
endtask

// One element, both strobes in the same cycle
task automatic smallest_size();
  int unsigned errors_before;
  errors_before = error_count;
  fill_random(1, 1, 1);
  run_case(1, 1, 1);
  finish_test("smallest 1x1x1", errors_before);
endtask

task automatic non_square_sizes();
  int unsigned errors_before;
  errors_before = error_count;
  fill_random(3, 5, 2);
  run_case(3, 5, 2);
  finish_test("non-square 3x5x2", errors_before);
endtask

task automatic sums_wrap_around();
  int unsigned errors_before;
  errors_before = error_count;
  fill_near_max(2, 8, 3);
  run_case(2, 8, 3);
  finish_test("wrap near 0xFFFF", errors_before);
endtask

// Second load uses other sizes, loader must start again from row 0
task automatic back_to_back_runs();
  int unsigned errors_before;
  errors_before = error_count;
  fill_random(2, 6, 4);
  run_case(2, 6, 4);
  fill_random(3, 4, 5);
  run_case(3, 4, 5);
  finish_test("back to back", errors_before);
endtask

// File: verification/dnc_read_vectors_tb.sv
// Testbench for the DNC read vector unit, runs the included scenarios and checks R_OUT
`timescale 1ns/1ps

module dnc_read_vectors_tb
  import dnc_read_pkg::*;
();

  // Six runs take about 900 cycles, the limit leaves wide margin
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  logic  CLK;
  logic  RST;
  logic  START;
  logic  READY;
  size_t SIZE_R_IN;
  size_t SIZE_N_IN;
  size_t SIZE_W_IN;
  data_t M_IN;
  logic  M_IN_J_ENABLE;
  logic  M_IN_K_ENABLE;
  data_t W_IN;
  logic  W_IN_I_ENABLE;
  logic  W_IN_J_ENABLE;
  data_t R_OUT;
  logic  R_OUT_I_ENABLE;
  logic  R_OUT_K_ENABLE;

  // Operand images, loaded into the DUT and read by the reference
  data_t m_mat [MAX_N][MAX_W];
  data_t w_mat [MAX_R][MAX_N];

  // Pending results in i-then-k order, with the head strobe expected
  data_t exp_val_q[$];
  logic  exp_first_q[$];
  data_t cmp_val;
  logic  cmp_first;

  // Run and score bookkeeping
  int unsigned cycle_count = 0;
  int unsigned exp_strobes = 0;
  int unsigned strobe_count = 0;
  int unsigned last_strobe_cycle = 0;
  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
    end
    $display("Timeout after %0d cycles, the DUT did not finish all runs", cycle_count);
    $display("STATUS: FAIL");
    $finish;
  end

  dnc_read_vectors i_dnc_read_vectors (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .SIZE_R_IN      (SIZE_R_IN),
    .SIZE_N_IN      (SIZE_N_IN),
    .SIZE_W_IN      (SIZE_W_IN),
    .M_IN           (M_IN),
    .M_IN_J_ENABLE  (M_IN_J_ENABLE),
    .M_IN_K_ENABLE  (M_IN_K_ENABLE),
    .W_IN           (W_IN),
    .W_IN_I_ENABLE  (W_IN_I_ENABLE),
    .W_IN_J_ENABLE  (W_IN_J_ENABLE),
    .R_OUT          (R_OUT),
    .R_OUT_I_ENABLE (R_OUT_I_ENABLE),
    .R_OUT_K_ENABLE (R_OUT_K_ENABLE)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // r(i,k) is the sum over j of w(i,j)*M(j,k), low 16 bits kept
  function automatic data_t read_element(int i, int k, int n);
    logic [31:0] sum;
    sum = '0;
    for (int j = 0; j < n; j++) begin
      sum = sum + w_mat[i][j] * m_mat[j][k];
    end
    return data_t'(sum);
  endfunction

  // Whole result in output order, i outer and k inner
  task automatic build_expected(int r, int n, int w);
    exp_val_q.delete();
    exp_first_q.delete();
    for (int i = 0; i < r; i++) begin
      for (int k = 0; k < w; k++) begin
        exp_val_q.push_back(read_element(i, k, n));
        exp_first_q.push_back(k == 0);
      end
    end
    exp_strobes = r * w;
  endtask

  task automatic report_mismatch(string sig, logic [31:0] expected, logic [31:0] actual);
    $display("[FAIL] t=%0t %s expected %0h got %0h", $time, sig, expected, actual);
    error_count++;
  endtask

  //////////////////////////////
  // Output compare
  //////////////////////////////

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (R_OUT_K_ENABLE === 1'b1) begin
        if (exp_val_q.size() == 0) begin
          $display("Output strobe at %0t with no result pending", $time);
          error_count++;
        end else begin
          cmp_val = exp_val_q.pop_front();
          cmp_first = exp_first_q.pop_front();
          check_count += 2;
          if (R_OUT !== cmp_val) begin
            report_mismatch("R_OUT", cmp_val, R_OUT);
          end
          if (R_OUT_I_ENABLE !== cmp_first) begin
            report_mismatch("R_OUT_I_ENABLE", cmp_first, R_OUT_I_ENABLE);
          end
        end
        // One element per N+2 cycles
        if (strobe_count != 0) begin
          check_count++;
          if (cycle_count - last_strobe_cycle != SIZE_N_IN + 2) begin
            report_mismatch("strobe spacing", SIZE_N_IN + 2, cycle_count - last_strobe_cycle);
          end
        end
        strobe_count++;
        last_strobe_cycle = cycle_count;
      end
      // End of run, nothing may be left over
      if (READY === 1'b1) begin
        check_count += 3;
        if (exp_val_q.size() != 0) begin
          $display("READY at %0t with %0d results never delivered", $time, exp_val_q.size());
          error_count++;
        end
        if (strobe_count != exp_strobes) begin
          report_mismatch("R_OUT_K_ENABLE count", exp_strobes, strobe_count);
        end
        // READY in the cycle right after the last strobe
        if (cycle_count - last_strobe_cycle != 1) begin
          report_mismatch("READY delay", 1, cycle_count - last_strobe_cycle);
        end
        strobe_count = 0;
      end
    end
  end

  `include "dnc_read_vectors_tests.svh"

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    void'($urandom(42));
    RST = 1'b1;
    START = 1'b0;
    SIZE_R_IN = size_t'(1);
    SIZE_N_IN = size_t'(1);
    SIZE_W_IN = size_t'(1);
    M_IN = '0;
    M_IN_J_ENABLE = 1'b0;
    M_IN_K_ENABLE = 1'b0;
    W_IN = '0;
    W_IN_I_ENABLE = 1'b0;
    W_IN_J_ENABLE = 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    idle_after_reset();
    full_size_random();
    smallest_size();
    non_square_sizes();
    sums_wrap_around();
    back_to_back_runs();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
